// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fftAccelTb
FILELIST  = fftAccel.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSMSG   = Simulation completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: fftAccel.f
logic/fftPkg.sv
logic/ramPortIf.sv
logic/twiddleRom.sv
logic/butterflyUnit.sv
logic/addressGenerator.sv
logic/fftRam.sv
logic/fftControl.sv
logic/fftAccel.sv
tb/fftAccelTb.sv

// File: logic/addressGenerator.sv
`timescale 1ns/1ps

// natural-order data in, bit-reversed results out: the span starts at
// NPOINTS/2 and halves each stage, and the twiddles run in bit-reversed order
module addressGenerator (
    input  logic [fftPkg::STAGEW-1:0] stage,
    input  logic [fftPkg::IDXW-2:0]   pairCount,
    input  logic [fftPkg::IDXW-1:0]   unloadCount,
    output logic [fftPkg::IDXW-1:0]   idxA,
    output logic [fftPkg::IDXW-1:0]   idxB,
    output logic [fftPkg::IDXW-2:0]   twIndex,
    output logic [fftPkg::IDXW-1:0]   revIndex
);

    logic [fftPkg::STAGEW-1:0] spanBit;                  // log2 of the butterfly span
    logic [fftPkg::IDXW-1:0]   spanOne;
    logic [fftPkg::IDXW-1:0]   lowMask;
    logic [fftPkg::IDXW-1:0]   pairWide;
    logic [fftPkg::IDXW-2:0]   pairRev;

    assign spanBit  = fftPkg::LASTSTAGE - stage;
    assign spanOne  = {{(fftPkg::IDXW-1){1'b0}}, 1'b1} << spanBit;
    assign lowMask  = spanOne - 1'b1;
    assign pairWide = {1'b0, pairCount};

    assign idxA    = ((pairWide & ~lowMask) << 1) | (pairWide & lowMask);  // zero at spanBit
    assign idxB    = idxA | spanOne;
    assign twIndex = pairRev << spanBit;                 // group number, reversed

    always_comb begin
        for (int i = 0; i < fftPkg::IDXW - 1; i++) begin
            pairRev[i] = pairCount[fftPkg::IDXW-2-i];
        end
        for (int i = 0; i < fftPkg::IDXW; i++) begin
            revIndex[i] = unloadCount[fftPkg::IDXW-1-i];
        end
    end

endmodule

// File: logic/butterflyUnit.sv
`timescale 1ns/1ps

module butterflyUnit (
    input  logic         clk,
    input  logic         rst,
    input  fftPkg::cplxT a,
    input  fftPkg::cplxT b,
    input  fftPkg::cplxT twiddle,
    output fftPkg::cplxT outA,
    output fftPkg::cplxT outB
);

    logic signed [2*fftPkg::DW:0]   prodRe;              // full precision W*b
    logic signed [2*fftPkg::DW:0]   prodIm;
    logic signed [2*fftPkg::DW:0]   rndRe;
    logic signed [2*fftPkg::DW:0]   rndIm;
    logic signed [fftPkg::DW+1:0]   wbRe;                // W*b back in Q1.15, two guard bits
    logic signed [fftPkg::DW+1:0]   wbIm;
    logic signed [fftPkg::DW+1:0]   aRe;
    logic signed [fftPkg::DW+1:0]   aIm;
    logic signed [fftPkg::DW+1:0]   sumRe;
    logic signed [fftPkg::DW+1:0]   sumIm;
    logic signed [fftPkg::DW+1:0]   difRe;
    logic signed [fftPkg::DW+1:0]   difIm;

    always_comb begin
        prodRe = twiddle.re * b.re - twiddle.im * b.im;
        prodIm = twiddle.re * b.im + twiddle.im * b.re;
        rndRe  = prodRe + (1 <<< (fftPkg::DW - 2));      // round half up
        rndIm  = prodIm + (1 <<< (fftPkg::DW - 2));
        wbRe   = rndRe[2*fftPkg::DW:fftPkg::DW-1];
        wbIm   = rndIm[2*fftPkg::DW:fftPkg::DW-1];
        aRe    = {{2{a.re[fftPkg::DW-1]}}, a.re};
        aIm    = {{2{a.im[fftPkg::DW-1]}}, a.im};
        sumRe  = aRe + wbRe;
        sumIm  = aIm + wbIm;
        difRe  = aRe - wbRe;
        difIm  = aIm - wbIm;
    end

    // each stage halves its result, so a whole transform carries 1/N
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outA <= '0;
            outB <= '0;
        end else begin
            outA.re <= sumRe[fftPkg::DW:1];              // arithmetic >>> 1
            outA.im <= sumIm[fftPkg::DW:1];
            outB.re <= difRe[fftPkg::DW:1];
            outB.im <= difIm[fftPkg::DW:1];
        end
    end

endmodule

// File: logic/fftAccel.sv
`timescale 1ns/1ps

module fftAccel (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inValid,
    input  logic signed [fftPkg::DW-1:0] inReal,
    input  logic signed [fftPkg::DW-1:0] inImag,
    output logic                        inCredit,
    input  logic                        start,
    input  logic                        inverse,
    input  logic                        outCredit,
    output logic                        outValid,
    output logic signed [fftPkg::DW-1:0] outReal,
    output logic signed [fftPkg::DW-1:0] outImag,
    output logic                        busy,
    output logic                        done
);

    fftPkg::cplxT              inSample;
    fftPkg::cplxT              outSample;
    fftPkg::cplxT              twiddle;
    fftPkg::cplxT              bflyA;
    fftPkg::cplxT              bflyB;
    logic [fftPkg::IDXW-1:0]   idxA;
    logic [fftPkg::IDXW-1:0]   idxB;
    logic [fftPkg::IDXW-1:0]   revIndex;
    logic [fftPkg::IDXW-1:0]   unloadCount;
    logic [fftPkg::IDXW-2:0]   pairCount;
    logic [fftPkg::IDXW-2:0]   twIndex;
    logic [fftPkg::STAGEW-1:0] stage;
    logic                      inverseLatched;

    ramPortIf portA ();
    ramPortIf portB ();

    assign inSample = '{re: inReal, im: inImag};
    assign outReal  = outSample.re;
    assign outImag  = outSample.im;

    fftControl fftControl_i (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inData(inSample), .inCredit(inCredit),
        .start(start), .inverse(inverse),
        .outCredit(outCredit), .outValid(outValid), .outData(outSample),
        .busy(busy), .done(done),
        .portA(portA.master), .portB(portB.master),
        .idxA(idxA), .idxB(idxB), .revIndex(revIndex),
        .stage(stage), .pairCount(pairCount), .unloadCount(unloadCount),
        .bflyA(bflyA), .bflyB(bflyB), .inverseLatched(inverseLatched)
    );

    addressGenerator addressGenerator_i (
        .stage(stage), .pairCount(pairCount), .unloadCount(unloadCount),
        .idxA(idxA), .idxB(idxB), .twIndex(twIndex), .revIndex(revIndex)
    );

    twiddleRom twiddleRom_i (
        .clk(clk), .twIndex(twIndex), .inverse(inverseLatched), .twiddle(twiddle)
    );

    butterflyUnit butterflyUnit_i (
        .clk(clk), .rst(rst),
        .a(portA.rdData), .b(portB.rdData), .twiddle(twiddle),
        .outA(bflyA), .outB(bflyB)
    );

    fftRam fftRam_i (
        .clk(clk), .portA(portA.memory), .portB(portB.memory)
    );

endmodule

// File: logic/fftControl.sv
`timescale 1ns/1ps

module fftControl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    input  fftPkg::cplxT              inData,
    output logic                      inCredit,
    input  logic                      start,
    input  logic                      inverse,
    input  logic                      outCredit,
    output logic                      outValid,
    output fftPkg::cplxT              outData,
    output logic                      busy,
    output logic                      done,
    ramPortIf.master                  portA,
    ramPortIf.master                  portB,
    input  logic [fftPkg::IDXW-1:0]   idxA,
    input  logic [fftPkg::IDXW-1:0]   idxB,
    input  logic [fftPkg::IDXW-1:0]   revIndex,
    output logic [fftPkg::STAGEW-1:0] stage,
    output logic [fftPkg::IDXW-2:0]   pairCount,
    output logic [fftPkg::IDXW-1:0]   unloadCount,
    input  fftPkg::cplxT              bflyA,
    input  fftPkg::cplxT              bflyB,
    output logic                      inverseLatched
);

    fftPkg::fftStateT          state;
    logic [fftPkg::IDXW-1:0]   loadCount;
    logic                      loadValid;                // beat waiting for its RAM write
    fftPkg::cplxT              loadData;
    logic                      frameLoaded;
    logic [fftPkg::DRAINW-1:0] drainCount;
    logic [fftPkg::IDXW:0]     outCredits;               // output credits held
    logic                      startAccept;
    logic                      unloadIssue;
    logic                      lastPair;
    logic                      lastDrain;
    logic                      lastBeat;
    logic [fftPkg::WBLAST:0]   wbValid;
    logic [fftPkg::IDXW-1:0]   wbAddrA [fftPkg::WBLAST+1];
    logic [fftPkg::IDXW-1:0]   wbAddrB [fftPkg::WBLAST+1];

    assign startAccept = (state == fftPkg::LOAD) && frameLoaded && start;
    assign unloadIssue = (state == fftPkg::UNLOAD) && (outCredits != '0);
    assign lastPair    = pairCount == (fftPkg::IDXW-1)'(fftPkg::NPOINTS / 2 - 1);
    assign lastDrain   = drainCount == fftPkg::DRAINW'(fftPkg::PIPEDEPTH - 1);
    assign lastBeat    = unloadCount == fftPkg::IDXW'(fftPkg::NPOINTS - 1);

    ////////////////////////////////////////////////////////////
    // state machine and counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= fftPkg::IDLE;
            stage          <= '0;
            pairCount      <= '0;
            drainCount     <= '0;
            unloadCount    <= '0;
            inverseLatched <= 1'b0;
        end else begin
            case (state)
                fftPkg::IDLE: begin
                    if (inValid) state <= fftPkg::LOAD;
                end
                fftPkg::LOAD: begin
                    if (startAccept) begin
                        state          <= fftPkg::COMPUTE;
                        inverseLatched <= inverse;
                    end
                end
                fftPkg::COMPUTE: begin
                    pairCount <= pairCount + 1'b1;       // one butterfly per cycle
                    if (lastPair) state <= fftPkg::DRAIN;
                end
                fftPkg::DRAIN: begin
                    drainCount <= lastDrain ? '0 : drainCount + 1'b1;
                    if (lastDrain) begin
                        stage <= (stage == fftPkg::LASTSTAGE) ? '0 : stage + 1'b1;
                        state <= (stage == fftPkg::LASTSTAGE) ? fftPkg::UNLOAD
                                                              : fftPkg::COMPUTE;
                    end
                end
                fftPkg::UNLOAD: begin
                    if (unloadIssue) begin
                        unloadCount <= unloadCount + 1'b1;
                        if (lastBeat) state <= fftPkg::IDLE;
                    end
                end
                default: state <= fftPkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // load side and host handshakes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadValid   <= 1'b0;
            loadCount   <= '0;
            frameLoaded <= 1'b0;
            outCredits  <= '0;
            outValid    <= 1'b0;
            done        <= 1'b0;
            busy        <= 1'b0;
        end else begin
            loadValid <= inValid && (state == fftPkg::IDLE || state == fftPkg::LOAD);
            if (loadValid) begin
                loadCount <= loadCount + 1'b1;
                if (loadCount == fftPkg::IDXW'(fftPkg::NPOINTS - 1)) frameLoaded <= 1'b1;
            end else if (startAccept) begin
                frameLoaded <= 1'b0;
            end
            outCredits <= outCredits + (fftPkg::IDXW+1)'(outCredit)
                                     - (fftPkg::IDXW+1)'(unloadIssue);
            outValid   <= unloadIssue;                   // read data lands next cycle
            done       <= unloadIssue && lastBeat;
            if (startAccept) begin
                busy <= 1'b1;
            end else if (unloadIssue && lastBeat) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        loadData <= inData;
    end

    assign inCredit = loadValid;                         // credit back as the sample lands
    assign outData  = portA.rdData;

    ////////////////////////////////////////////////////////////
    // write-back pipe matching the RAM read and butterfly register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbValid <= '0;
        end else begin
            wbValid <= (fftPkg::WBLAST+1)'({wbValid, state == fftPkg::COMPUTE});
        end
    end

    always_ff @(posedge clk) begin
        wbAddrA[0] <= idxA;
        wbAddrB[0] <= idxB;
        for (int i = 1; i <= fftPkg::WBLAST; i++) begin
            wbAddrA[i] <= wbAddrA[i-1];
            wbAddrB[i] <= wbAddrB[i-1];
        end
    end

    // port A is shared by load, butterfly and unload; port B only serves butterflies
    assign portA.rdAddr = (state == fftPkg::UNLOAD) ? revIndex : idxA;
    assign portA.wrEn   = wbValid[fftPkg::WBLAST] | loadValid;
    assign portA.wrAddr = wbValid[fftPkg::WBLAST] ? wbAddrA[fftPkg::WBLAST] : loadCount;
    assign portA.wrData = wbValid[fftPkg::WBLAST] ? bflyA : loadData;
    assign portB.rdAddr = idxB;
    assign portB.wrEn   = wbValid[fftPkg::WBLAST];
    assign portB.wrAddr = wbAddrB[fftPkg::WBLAST];
    assign portB.wrData = bflyB;

    inBeatWhenBusy: assert property (@(posedge clk) disable iff (rst)
        inValid |-> (state == fftPkg::IDLE || state == fftPkg::LOAD))
        else $error("fftControl: inValid while the transform is running");

    outCreditWrap: assert property (@(posedge clk) disable iff (rst)
        !(outCredit && !unloadIssue && outCredits == '1))
        else $error("fftControl: output credit count wrapped");

endmodule

// File: logic/fftPkg.sv
package fftPkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int NPOINTS   = 16;                       // samples per frame
    localparam int LOGN      = 4;                        // radix-2 stages
    localparam int IDXW      = 4;                        // sample index width
    localparam int DW        = 16;                       // width of re and im
    localparam int CREDITS   = 4;                        // host input credits after reset
    localparam int PIPEDEPTH = 3;                        // butterfly read to write-back

    localparam int STAGEW = $clog2(LOGN);                // stage counter width
    localparam int DRAINW = $clog2(PIPEDEPTH);           // drain counter width
    localparam int WBLAST = PIPEDEPTH - 2;               // last write-back pipe slot
    localparam logic [STAGEW-1:0] LASTSTAGE = STAGEW'(LOGN - 1);

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic signed [DW-1:0] re;                        // Q1.15 real part
        logic signed [DW-1:0] im;                        // Q1.15 imaginary part
    } cplxT;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        DRAIN,
        UNLOAD
    } fftStateT;

endpackage

// File: logic/fftRam.sv
`timescale 1ns/1ps

module fftRam (
    input  logic     clk,
    ramPortIf.memory portA,
    ramPortIf.memory portB
);

    fftPkg::cplxT mem [fftPkg::NPOINTS];

    always_ff @(posedge clk) begin
        if (portA.wrEn) begin
            mem[portA.wrAddr] <= portA.wrData;
        end
        if (portB.wrEn) begin
            mem[portB.wrAddr] <= portB.wrData;
        end
        portA.rdData <= mem[portA.rdAddr];               // old data on a same-cycle write
        portB.rdData <= mem[portB.rdAddr];
    end

    // the controller must never steer both ports onto one word
    wrCollision: assert property (@(posedge clk)
        !(portA.wrEn && portB.wrEn && portA.wrAddr == portB.wrAddr))
        else $error("fftRam: both ports write address %0d", portA.wrAddr);

endmodule

// File: logic/ramPortIf.sv
`timescale 1ns/1ps

interface ramPortIf;

    logic [fftPkg::IDXW-1:0] rdAddr;                     // sampled at the edge, data next cycle
    logic [fftPkg::IDXW-1:0] wrAddr;
    fftPkg::cplxT            wrData;
    logic                    wrEn;
    fftPkg::cplxT            rdData;

    modport master (
        output rdAddr,
        output wrAddr,
        output wrData,
        output wrEn,
        input  rdData
    );

    modport memory (
        input  rdAddr,
        input  wrAddr,
        input  wrData,
        input  wrEn,
        output rdData
    );

endinterface

// File: logic/twiddleRom.sv
`timescale 1ns/1ps

module twiddleRom (
    input  logic                    clk,
    input  logic [fftPkg::IDXW-2:0] twIndex,
    input  logic                    inverse,
    output fftPkg::cplxT            twiddle
);

    fftPkg::cplxT factor;                                // W^k = cos - j*sin

    // first half of the unit circle, Q1.15
    always_comb begin
        case (twIndex)
            3'd0:    factor = '{re:  16'sd32767, im:  16'sd0};
            3'd1:    factor = '{re:  16'sd30274, im: -16'sd12540};
            3'd2:    factor = '{re:  16'sd23170, im: -16'sd23170};
            3'd3:    factor = '{re:  16'sd12540, im: -16'sd30274};
            3'd4:    factor = '{re:  16'sd0,     im: -16'sd32767};
            3'd5:    factor = '{re: -16'sd12540, im: -16'sd30274};
            3'd6:    factor = '{re: -16'sd23170, im: -16'sd23170};
            default: factor = '{re: -16'sd30274, im: -16'sd12540};
        endcase
    end

    always_ff @(posedge clk) begin
        twiddle.re <= factor.re;
        twiddle.im <= inverse ? -factor.im : factor.im;  // conjugate for the inverse
    end

endmodule

// File: tb/fftAccelTb.sv
`timescale 1ns/1ps

module fftAccelTb;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         inValid;
    logic signed [fftPkg::DW-1:0] inReal;
    logic signed [fftPkg::DW-1:0] inImag;
    logic                         inCredit;
    logic                         start;
    logic                         inverse;
    logic                         outCredit = 1'b0;
    logic                         outValid;
    logic signed [fftPkg::DW-1:0] outReal;
    logic signed [fftPkg::DW-1:0] outImag;
    logic                         busy;
    logic                         done;

    int  valueErrors;
    int  protocolErrors;
    int  beatsSent;                                      // input beats driven
    int  creditsBack;                                    // inCredit pulses seen
    int  grantsSeen;                                     // outCredit pulses seen
    int  beatsSeen;                                      // outValid beats seen
    int  beatIndex;                                      // bin of the next output beat
    int  framesDone;
    int  grantCycle;
    int  stimRe [fftPkg::NPOINTS];
    int  stimIm [fftPkg::NPOINTS];
    int  randRe [2*fftPkg::NPOINTS];
    int  randIm [2*fftPkg::NPOINTS];
    real expRe  [fftPkg::NPOINTS];
    real expIm  [fftPkg::NPOINTS];
    bit  grantPattern [1024];

    fftAccel fftAccel_i (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReal(inReal), .inImag(inImag), .inCredit(inCredit),
        .start(start), .inverse(inverse),
        .outCredit(outCredit), .outValid(outValid), .outReal(outReal), .outImag(outImag),
        .busy(busy), .done(done)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic int roundToInt(real v);
        return (v >= 0.0) ? $rtoi(v + 0.5) : $rtoi(v - 0.5);
    endfunction

    function automatic bit withinTol(int got, real want);
        real diff;
        diff = $itor(got) - want;
        return (diff <= 4.0) && (diff >= -4.0);
    endfunction

    // DFT of the stimulus scaled by 1/N in the direction set by inv
    task automatic referenceDft(input bit inv);
        int  k;
        int  n;
        real angle;
        real c;
        real s;
        real accRe;
        real accIm;
        for (k = 0; k < fftPkg::NPOINTS; k++) begin
            accRe = 0.0;
            accIm = 0.0;
            for (n = 0; n < fftPkg::NPOINTS; n++) begin
                angle = 2.0 * 3.141592653589793 * n * k / fftPkg::NPOINTS;
                c     = $cos(angle);
                s     = inv ? $sin(angle) : -$sin(angle);
                accRe = accRe + stimRe[n] * c - stimIm[n] * s;
                accIm = accIm + stimRe[n] * s + stimIm[n] * c;
            end
            expRe[k] = accRe / fftPkg::NPOINTS;
            expIm[k] = accIm / fftPkg::NPOINTS;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // load one frame under input credits, start it and wait for done
    task automatic runFrame(input bit inv);
        int idx;
        int framesBefore;
        framesBefore = framesDone;
        referenceDft(inv);
        idx = 0;
        while (idx < fftPkg::NPOINTS) begin
            nextCycle();
            if (beatsSent - creditsBack < fftPkg::CREDITS) begin
                inValid = 1'b1;
                inReal  = 16'(stimRe[idx]);
                inImag  = 16'(stimIm[idx]);
                beatsSent++;
                idx++;
            end else begin
                inValid = 1'b0;                          // waiting for a credit
            end
        end
        nextCycle();
        inValid = 1'b0;
        start   = 1'b1;
        inverse = inv;
        do nextCycle(); while (!busy);
        start = 1'b0;
        while (framesDone == framesBefore) nextCycle();
        repeat (3) nextCycle();
    endtask

    ////////////////////////////////////////////////////////////
    // host output credits and monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        outCredit  = !rst && grantPattern[grantCycle] && (grantsSeen - beatsSeen < 8);
        grantCycle = (grantCycle + 1) % 1024;
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (inCredit) creditsBack++;
            if (outCredit) grantsSeen++;
            assert (beatsSent - creditsBack >= 0 && beatsSent - creditsBack <= fftPkg::CREDITS)
                else begin
                    protocolErrors++;
                    $display("input credits out of range, %0d outstanding",
                             beatsSent - creditsBack);
                end
            if (outValid) begin
                beatsSeen++;
                assert (beatsSeen <= grantsSeen) else begin
                    protocolErrors++;
                    $display("output beat %0d sent without a granted credit", beatsSeen);
                end
                assert (withinTol(outReal, expRe[beatIndex])) else begin
                    valueErrors++;
                    $display("error outReal bin %0d got %h expected %h", beatIndex, outReal,
                             16'(roundToInt(expRe[beatIndex])));
                end
                assert (withinTol(outImag, expIm[beatIndex])) else begin
                    valueErrors++;
                    $display("error outImag bin %0d got %h expected %h", beatIndex, outImag,
                             16'(roundToInt(expIm[beatIndex])));
                end
            end
            assert (done == (outValid && beatIndex == fftPkg::NPOINTS - 1)) else begin
                protocolErrors++;
                $display("done did not line up with the last output beat");
            end
            if (outValid) beatIndex = (beatIndex + 1) % fftPkg::NPOINTS;
            if (done) begin
                assert (beatsSent == creditsBack) else begin
                    protocolErrors++;
                    $display("input credits not all returned by the end of the frame");
                end
                framesDone++;
            end
        end
    end

    doneEndsBusy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            protocolErrors++;
            $display("busy still high while done pulsed");
        end

    loadBetweenFrames: assert property (@(posedge clk) disable iff (rst) inValid |-> !busy)
        else begin
            protocolErrors++;
            $display("input beat arrived while busy was high");
        end

    creditFollowsBeat: assert property (@(posedge clk) disable iff (rst) inValid |=> inCredit)
        else begin
            protocolErrors++;
            $display("no credit returned one cycle after an input beat");
        end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int i;
        rst     = 1'b1;
        inValid = 1'b0;
        inReal  = '0;
        inImag  = '0;
        start   = 1'b0;
        inverse = 1'b0;
        void'($urandom(59377));
        for (i = 0; i < 2 * fftPkg::NPOINTS; i++) begin
            randRe[i] = int'($urandom_range(0, 'h2000)) - 'h1000;
            randIm[i] = int'($urandom_range(0, 'h2000)) - 'h1000;
        end
        for (i = 0; i < 1024; i++) begin
            grantPattern[i] = ($urandom_range(0, 3) == 0);   // about one grant in four
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!inCredit && !outValid && !busy && !done) else begin
            protocolErrors++;
            $display("outputs not idle after reset");
        end

        for (i = 0; i < fftPkg::NPOINTS; i++) begin
            stimRe[i] = (i == 0) ? 'h4000 : 0;           // impulse
            stimIm[i] = 0;
        end
        runFrame(1'b0);
        for (i = 0; i < fftPkg::NPOINTS; i++) stimRe[i] = 'h2000;
        runFrame(1'b0);
        for (i = 0; i < fftPkg::NPOINTS; i++) begin
            stimRe[i] = randRe[i];
            stimIm[i] = randIm[i];
        end
        runFrame(1'b0);
        for (i = 0; i < fftPkg::NPOINTS; i++) begin
            stimRe[i] = roundToInt(expRe[i]);            // spectrum goes back in
            stimIm[i] = roundToInt(expIm[i]);
        end
        runFrame(1'b1);
        for (i = 0; i < fftPkg::NPOINTS; i++) begin
            stimRe[i] = randRe[fftPkg::NPOINTS + i];
            stimIm[i] = randIm[fftPkg::NPOINTS + i];
        end
        runFrame(1'b0);

        $display("errors: value %0d protocol %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // six frames of load, compute and a slow unload
    initial begin
        #(6 * (fftPkg::NPOINTS + fftPkg::LOGN * (fftPkg::NPOINTS / 2 + fftPkg::PIPEDEPTH)
               + fftPkg::NPOINTS * 8) * 4);
        $display("timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule
